// File: src/pc_bus_settings.svh
`ifndef PC_BUS_SETTINGS_SVH
`define PC_BUS_SETTINGS_SVH

// Bus widths, address runs from ADR_W down to bit 1
`define DAT_W 16
`define ADR_W 19

// Word RAM size in address bits
`define RAM_ADDR_BITS 12

// Memory region, matched against address bits 19:16
`define RAM_REGION_TOP 4'h0

// I/O map
`define LED_IO_PAGE   8'hF1
`define SWITCH_IO_ADR 16'h0102
`define PIC_IO_BASE   16'h0020

// Periodic interrupt source
`define TIMER_PERIOD 1000
`define TIMER_IRQ    0

// Interrupt acknowledge and open bus values
`define INTA_VECTOR_BASE 13'h0001
`define UNMAPPED_READ    16'hFFFF

`endif

// File: src/pc_bus_pkg.sv
package pc_bus_pkg;

  // Target of the bus cycle currently on the master port
  typedef enum logic [2:0] {
    REGION_NONE   = 3'd0,
    REGION_RAM    = 3'd1,
    REGION_LED    = 3'd2,
    REGION_SWITCH = 3'd3,
    REGION_PIC    = 3'd4
  } region_e;

  // Interrupt controller registers, picked by address bit 1
  // Pending is read only, mask is read/write
  typedef enum logic {
    PIC_PENDING = 1'b0,
    PIC_MASK    = 1'b1
  } pic_reg_e;

endpackage

// File: src/bus_decoder.sv
`timescale 1ns/1ps
`include "pc_bus_settings.svh"

module bus_decoder (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic [`ADR_W:1]   adr_i,
  input  logic [`DAT_W-1:0] dat_i,
  input  logic              we_i,
  input  logic              tga_i,
  input  logic [1:0]        sel_i,
  input  logic              stb_i,
  input  logic              cyc_i,
  input  logic              inta_i,
  input  logic [7:0]        sw_i,
  input  logic              ram_ack_i,
  input  logic [`DAT_W-1:0] ram_dat_i,
  input  logic [7:0]        pic_dat_i,
  input  logic [2:0]        iid_i,
  output logic              ram_stb_o,
  output logic              pic_stb_o,
  output logic [`DAT_W-1:0] dat_o,
  output logic              ack_o,
  output logic [`DAT_W-1:0] led_o
);

  pc_bus_pkg::region_e region;
  logic                bus_req;
  logic                led_wr;
  logic [`DAT_W-1:0]   led_q;

  assign bus_req = stb_i & cyc_i;

  // Memory cycles only ever hit RAM, I/O cycles go by port address
  always_comb begin
    region = pc_bus_pkg::REGION_NONE;
    if (!tga_i) begin
      if (adr_i[`ADR_W:16] == `RAM_REGION_TOP) begin
        region = pc_bus_pkg::REGION_RAM;
      end
    end else if (adr_i[15:8] == `LED_IO_PAGE) begin
      region = pc_bus_pkg::REGION_LED;
    end else if ({adr_i[15:1], 1'b0} == `SWITCH_IO_ADR) begin
      region = pc_bus_pkg::REGION_SWITCH;
    end else if ({adr_i[15:2], 2'b00} == `PIC_IO_BASE) begin
      // Pending at base, mask at base+2
      region = pc_bus_pkg::REGION_PIC;
    end
  end

  assign ram_stb_o = bus_req && (region == pc_bus_pkg::REGION_RAM);
  assign pic_stb_o = bus_req && (region == pc_bus_pkg::REGION_PIC);

  // Only the RAM inserts wait states
  assign ack_o = (region == pc_bus_pkg::REGION_RAM) ? ram_ack_i : bus_req;

  // Vector wins while the CPU runs an interrupt acknowledge
  always_comb begin
    if (inta_i) begin
      dat_o = {`INTA_VECTOR_BASE, iid_i};
    end else begin
      case (region)
        pc_bus_pkg::REGION_RAM:    dat_o = ram_dat_i;
        pc_bus_pkg::REGION_LED:    dat_o = led_q;
        pc_bus_pkg::REGION_SWITCH: dat_o = {8'h00, sw_i};
        pc_bus_pkg::REGION_PIC:    dat_o = {8'h00, pic_dat_i};
        default:                   dat_o = `UNMAPPED_READ;
      endcase
    end
  end

  // Front panel LEDs, written per byte lane
  assign led_wr = bus_req && we_i && (region == pc_bus_pkg::REGION_LED);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      led_q <= '0;
    end else if (led_wr) begin
      if (sel_i[0]) begin
        led_q[7:0] <= dat_i[7:0];
      end
      if (sel_i[1]) begin
        led_q[15:8] <= dat_i[15:8];
      end
    end
  end

  assign led_o = led_q;

  // Master keeps a waiting cycle steady until its acknowledge
  a_cycle_held: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (bus_req && !ack_o) |=>
      (bus_req && $stable(adr_i) && $stable(we_i) && $stable(tga_i))
  ) else $error("bus_decoder: cycle changed before its acknowledge");

endmodule

// File: src/main_ram.sv
`timescale 1ns/1ps
`include "pc_bus_settings.svh"

module main_ram (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      stb_i,
  input  logic                      we_i,
  input  logic [`RAM_ADDR_BITS-1:0] adr_i,
  input  logic [1:0]                sel_i,
  input  logic [`DAT_W-1:0]         dat_i,
  output logic [`DAT_W-1:0]         dat_o,
  output logic                      ack_o
);

  localparam int unsigned DEPTH = 1 << `RAM_ADDR_BITS;

  logic [`DAT_W-1:0] mem [DEPTH];
  logic [`DAT_W-1:0] rd_q;
  logic              ack_q;
  logic              access;

  // One access per strobe, held off while the ack is up
  assign access = stb_i & ~ack_q;

  always_ff @(posedge clk) begin
    if (access) begin
      rd_q <= mem[adr_i];
      if (we_i && sel_i[0]) begin
        mem[adr_i][7:0] <= dat_i[7:0];
      end
      if (we_i && sel_i[1]) begin
        mem[adr_i][15:8] <= dat_i[15:8];
      end
    end
  end

  // Ack drops by itself the cycle after it rises
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign dat_o = rd_q;
  assign ack_o = ack_q;

  // Every ack answers a strobe that is still held for it
  a_ack_after_stb: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    ack_o |-> ($past(stb_i) && stb_i)
  ) else $error("main_ram: ack without a strobe held for it");

endmodule

// File: src/interval_timer.sv
`timescale 1ns/1ps
`include "pc_bus_settings.svh"

module interval_timer #(
  parameter int unsigned PERIOD = `TIMER_PERIOD
) (
  input  logic clk,
  input  logic rst_n_i,
  output logic tick_o
);

  localparam int unsigned CNT_W = $clog2(PERIOD);

  logic [CNT_W-1:0] cnt_q;
  logic             tick_q;
  logic             wrap;

  assign wrap = (cnt_q == CNT_W'(PERIOD - 1));

  // Tick is registered, so the first one lands PERIOD cycles after reset
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      tick_q <= 1'b0;
    end else begin
      tick_q <= wrap;
      if (wrap) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign tick_o = tick_q;

endmodule

// File: src/int_controller.sv
`timescale 1ns/1ps

module int_controller (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic [7:0]           irq_i,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  pc_bus_pkg::pic_reg_e reg_sel_i,
  input  logic [7:0]           dat_i,
  output logic [7:0]           dat_o,
  input  logic                 inta_i,
  output logic                 intr_o,
  output logic [2:0]           iid_o
);

  logic [7:0] irq_q;
  logic [7:0] irq_prev;
  logic [7:0] rise;
  logic [7:0] mask_q;
  logic [7:0] pending_q;
  logic [7:0] pending_d;
  logic       inta_q;
  logic       inta_rise;
  logic       intr_q;
  logic [2:0] iid_q;

  // Line 0 has the highest priority
  function automatic logic [2:0] lowest_set(input logic [7:0] vec);
    logic [2:0] idx;
    idx = 3'd0;
    for (int i = 7; i >= 0; i--) begin
      if (vec[i]) begin
        idx = 3'(i);
      end
    end
    return idx;
  endfunction

  // Masked lines are dropped before they can latch
  assign rise      = irq_q & ~irq_prev & ~mask_q;
  assign inta_rise = inta_i & ~inta_q;

  always_comb begin
    pending_d = pending_q | rise;
    if (inta_rise) begin
      pending_d[iid_q] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      irq_q     <= '0;
      irq_prev  <= '0;
      inta_q    <= 1'b0;
      pending_q <= '0;
      intr_q    <= 1'b0;
      iid_q     <= '0;
      mask_q    <= '0;
    end else begin
      irq_q     <= irq_i;
      irq_prev  <= irq_q;
      inta_q    <= inta_i;
      pending_q <= pending_d;
      intr_q    <= |pending_d;
      // iid frozen during acknowledge so the vector stays stable
      if (!inta_i) begin
        iid_q <= lowest_set(pending_d);
      end
      if (stb_i && we_i && (reg_sel_i == pc_bus_pkg::PIC_MASK)) begin
        mask_q <= dat_i;
      end
    end
  end

  assign dat_o  = (reg_sel_i == pc_bus_pkg::PIC_MASK) ? mask_q : pending_q;
  assign intr_o = intr_q;
  assign iid_o  = iid_q;

  // The CPU only acknowledges a raised request
  a_inta_on_intr: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    $rose(inta_i) |-> intr_o
  ) else $error("int_controller: interrupt acknowledge with no request");

endmodule

// File: src/pc_soc_top.sv
`timescale 1ns/1ps
`include "pc_bus_settings.svh"

module pc_soc_top (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic [`ADR_W:1]   adr_i,
  input  logic [`DAT_W-1:0] dat_i,
  input  logic              we_i,
  input  logic              tga_i,
  input  logic [1:0]        sel_i,
  input  logic              stb_i,
  input  logic              cyc_i,
  input  logic              inta_i,
  input  logic [7:1]        irq_i,
  input  logic [7:0]        sw_i,
  output logic [`DAT_W-1:0] dat_o,
  output logic              ack_o,
  output logic              intr_o,
  output logic [`DAT_W-1:0] led_o
);

  logic              ram_stb;
  logic              ram_ack;
  logic [`DAT_W-1:0] ram_dat;
  logic              pic_stb;
  logic [7:0]        pic_dat;
  logic [2:0]        iid;
  logic              timer_tick;
  logic [7:0]        irq_lines;

  // External sources on 7:1, timer on its own line
  assign irq_lines = {irq_i, 1'b0} | (8'(timer_tick) << `TIMER_IRQ);

  bus_decoder u_bus_decoder (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .adr_i     (adr_i),
    .dat_i     (dat_i),
    .we_i      (we_i),
    .tga_i     (tga_i),
    .sel_i     (sel_i),
    .stb_i     (stb_i),
    .cyc_i     (cyc_i),
    .inta_i    (inta_i),
    .sw_i      (sw_i),
    .ram_ack_i (ram_ack),
    .ram_dat_i (ram_dat),
    .pic_dat_i (pic_dat),
    .iid_i     (iid),
    .ram_stb_o (ram_stb),
    .pic_stb_o (pic_stb),
    .dat_o     (dat_o),
    .ack_o     (ack_o),
    .led_o     (led_o)
  );

  // RAM mirrors across the whole 64K region
  main_ram u_main_ram (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .stb_i   (ram_stb),
    .we_i    (we_i),
    .adr_i   (adr_i[`RAM_ADDR_BITS:1]),
    .sel_i   (sel_i),
    .dat_i   (dat_i),
    .dat_o   (ram_dat),
    .ack_o   (ram_ack)
  );

  interval_timer #(
    .PERIOD (`TIMER_PERIOD)
  ) u_interval_timer (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .tick_o  (timer_tick)
  );

  int_controller u_int_controller (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .irq_i     (irq_lines),
    .stb_i     (pic_stb),
    .we_i      (we_i),
    .reg_sel_i (pc_bus_pkg::pic_reg_e'(adr_i[1])),
    .dat_i     (dat_i[7:0]),
    .dat_o     (pic_dat),
    .inta_i    (inta_i),
    .intr_o    (intr_o),
    .iid_o     (iid)
  );

endmodule

// File: testbench/tb_pc_soc.sv
`timescale 1ns/1ps

module tb_pc_soc;

  localparam int SWEEP_WORDS = 24;
  localparam int ACK_TIMEOUT = 16;

  logic        clk;
  logic        rst_n;
  logic [19:1] adr;
  logic [15:0] wdat;
  logic        we;
  logic        tga;
  logic [1:0]  sel;
  logic        stb;
  logic        cyc;
  logic        inta;
  logic [7:1]  irq;
  logic [7:0]  sw;
  logic [15:0] rdat;
  logic        ack;
  logic        intr;
  logic [15:0] led;

  logic [31:0] lfsr_state;
  logic [15:0] sweep_exp [4096];
  logic [11:0] sweep_word [SWEEP_WORDS];
  int          cur_test;
  int          test_errs;
  int          err_count;
  int          tests_run;
  int          tests_failed;
  bit          timed_out;

  pc_soc_top u_pc_soc_top (
    .clk     (clk),
    .rst_n_i (rst_n),
    .adr_i   (adr),
    .dat_i   (wdat),
    .we_i    (we),
    .tga_i   (tga),
    .sel_i   (sel),
    .stb_i   (stb),
    .cyc_i   (cyc),
    .inta_i  (inta),
    .irq_i   (irq),
    .sw_i    (sw),
    .dat_o   (rdat),
    .ack_o   (ack),
    .intr_o  (intr),
    .led_o   (led)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // Right-shifting Galois LFSR
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ 32'h80200003;
    end
    return nxt;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < count; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return val;
  endfunction

  task automatic report_mismatch(input string what, input logic [15:0] got,
                                 input logic [15:0] exp);
    $display("CHECK FAILED at %0t: test %0d %s got %h, expected %h",
             $time, cur_test, what, got, exp);
    err_count++;
    test_errs++;
  endtask

  task automatic report_timeout(input string msg);
    $display("Timeout at %0t in test %0d: %s", $time, cur_test, msg);
    timed_out = 1'b1;
    err_count++;
    test_errs++;
  endtask

  task automatic close_test();
    if (cur_test != 0) begin
      tests_run++;
      if (test_errs == 0) begin
        $display("test %0d passed", cur_test);
      end else begin
        $display("test %0d failed with %0d errors", cur_test, test_errs);
        tests_failed++;
      end
    end
    test_errs = 0;
  endtask

  // Called and returns 1 ns after a rising edge
  task automatic idle_cycles(input int count);
    repeat (count) @(posedge clk);
    #1;
  endtask

  // Strobe held until the acknowledge is seen at a rising edge
  task automatic bus_cycle(input logic is_io, input logic [19:0] byte_adr, input logic write,
                           input logic [15:0] data, input logic [1:0] lanes,
                           output logic [15:0] got);
    int waited;
    tga = is_io;
    adr = byte_adr[19:1];
    wdat = data;
    we = write;
    sel = lanes;
    stb = 1'b1;
    cyc = 1'b1;
    waited = 0;
    got = '0;
    // Ack looked at mid-cycle, it then holds through the next rising edge
    do begin
      @(negedge clk);
      waited++;
    end while (!ack && waited < ACK_TIMEOUT);
    if (ack) begin
      got = rdat;
    end else begin
      report_timeout("no bus acknowledge");
    end
    @(posedge clk);
    #1;
    stb = 1'b0;
    cyc = 1'b0;
    we = 1'b0;
  endtask

  task automatic pulse_irq(input logic [2:0] line);
    logic [7:0] lines;
    lines = 8'h01 << line;
    irq = lines[7:1];
    idle_cycles(1);
    irq = '0;
    idle_cycles(3);
  endtask

  task automatic int_ack(output logic [15:0] vec);
    inta = 1'b1;
    @(negedge clk);
    vec = rdat;
    @(posedge clk);
    #1;
    inta = 1'b0;
    idle_cycles(3);
  endtask

  task automatic wait_intr(input int limit);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!intr && waited < limit);
    if (!intr) begin
      report_timeout("interrupt request never rose");
    end
    @(posedge clk);
    #1;
  endtask

  task automatic run_op(input int op, input logic [31:0] f_tga, input logic [31:0] f_adr,
                        input logic [31:0] f_dat, input logic [31:0] f_sel,
                        input logic [31:0] f_exp);
    logic [15:0] got;
    case (op)
      int'("W"): bus_cycle(f_tga[0], f_adr[19:0], 1'b1, f_dat[15:0], f_sel[1:0], got);
      int'("R"): begin
        bus_cycle(f_tga[0], f_adr[19:0], 1'b0, 16'h0000, f_sel[1:0], got);
        if (!timed_out && got !== f_exp[15:0]) begin
          report_mismatch("bus read", got, f_exp[15:0]);
        end
      end
      int'("S"): sw = f_dat[7:0];
      int'("L"): begin
        if (led !== f_exp[15:0]) begin
          report_mismatch("led_o", led, f_exp[15:0]);
        end
      end
      int'("I"): pulse_irq(f_dat[2:0]);
      int'("A"): begin
        int_ack(got);
        if (got !== f_exp[15:0]) begin
          report_mismatch("vector", got, f_exp[15:0]);
        end
      end
      int'("M"): wait_intr(int'(f_dat));
      int'("Q"): begin
        idle_cycles(2);
        if (intr !== f_exp[0]) begin
          report_mismatch("intr_o", {15'h0000, intr}, {15'h0000, f_exp[0]});
        end
      end
      default: begin
        $display("Unknown stimulus operation %c in test %0d", op, cur_test);
        err_count++;
        test_errs++;
      end
    endcase
  endtask

  // Random words through random mirrors of the RAM, read back through other mirrors
  task automatic ram_sweep();
    logic [15:0] got;
    logic [15:0] data;
    logic [2:0]  mirror;
    for (int i = 0; i < SWEEP_WORDS && !timed_out; i++) begin
      mirror = 3'(random_bits(3));
      sweep_word[i] = 12'(random_bits(12));
      data = 16'(random_bits(16));
      sweep_exp[sweep_word[i]] = data;
      bus_cycle(1'b0, {4'h0, mirror, sweep_word[i], 1'b0}, 1'b1, data, 2'b11, got);
    end
    for (int i = 0; i < SWEEP_WORDS && !timed_out; i++) begin
      mirror = 3'(random_bits(3));
      bus_cycle(1'b0, {4'h0, mirror, sweep_word[i], 1'b0}, 1'b0, 16'h0000, 2'b11, got);
      if (!timed_out && got !== sweep_exp[sweep_word[i]]) begin
        report_mismatch("RAM sweep read", got, sweep_exp[sweep_word[i]]);
      end
    end
  endtask

  initial begin
    int          fd;
    int          ch;
    int          n_read;
    int          line_test;
    bit          file_done;
    logic [31:0] f_tga;
    logic [31:0] f_adr;
    logic [31:0] f_dat;
    logic [31:0] f_sel;
    logic [31:0] f_exp;
    rst_n = 1'b0;
    adr = '0;
    wdat = '0;
    we = 1'b0;
    tga = 1'b0;
    sel = 2'b00;
    stb = 1'b0;
    cyc = 1'b0;
    inta = 1'b0;
    irq = '0;
    sw = '0;
    lfsr_state = 32'h6ed51bc3;
    cur_test = 0;
    test_errs = 0;
    err_count = 0;
    tests_run = 0;
    tests_failed = 0;
    timed_out = 1'b0;
    file_done = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    fd = $fopen("testbench/pc_soc_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file testbench/pc_soc_stimulus.txt");
      err_count++;
      file_done = 1'b1;
    end
    while (!file_done && !timed_out) begin
      ch = $fgetc(fd);
      if (ch == -1) begin
        file_done = 1'b1;
      end else if (ch == int'("#")) begin
        while (ch != int'("\n") && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else if (ch >= int'("A") && ch <= int'("Z")) begin
        n_read = $fscanf(fd, " %d %h %h %h %h %h", line_test, f_tga, f_adr, f_dat, f_sel,
                         f_exp);
        if (n_read != 6) begin
          $display("Stimulus file has a malformed line for operation %c", ch);
          err_count++;
          file_done = 1'b1;
        end else begin
          if (line_test != cur_test) begin
            close_test();
            cur_test = line_test;
          end
          run_op(ch, f_tga, f_adr, f_dat, f_sel, f_exp);
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    // Test 7 is the random RAM sweep
    if (!timed_out) begin
      close_test();
      cur_test = 7;
      ram_sweep();
    end
    close_test();
    $display("Tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: testbench/pc_soc_stimulus.txt
# op test tga address data sel expected, all hex except the decimal test number
# W write, R read, S set switches, L check LEDs, I pulse irq, A inta, M wait intr, Q check intr
W 1 0 00100 BEEF 3 0000
R 1 0 00100 0000 3 BEEF
W 1 0 00100 0011 1 0000
W 1 0 00100 2200 2 0000
R 1 0 00100 0000 3 2211
R 1 0 02100 0000 3 2211
W 2 1 0F100 1234 3 0000
W 2 1 0F102 ABCD 1 0000
W 2 1 0F100 5600 2 0000
L 2 0 00000 0000 0 56CD
R 2 1 0F100 0000 3 56CD
S 2 0 00000 00A5 0 0000
R 2 1 00102 0000 3 00A5
R 3 1 00300 0000 3 FFFF
W 3 1 00300 0000 3 0000
W 3 0 30100 0000 3 0000
L 3 0 00000 0000 0 56CD
R 3 0 00100 0000 3 2211
W 4 1 00022 0001 1 0000
I 4 0 00000 0005 0 0000
I 4 0 00000 0003 0 0000
M 4 0 00000 0014 0 0000
A 4 0 00000 0000 0 000B
A 4 0 00000 0000 0 000D
Q 4 0 00000 0000 0 0000
W 5 1 00022 0011 1 0000
I 5 0 00000 0004 0 0000
Q 5 0 00000 0000 0 0000
R 5 1 00022 0000 3 0011
W 6 1 00022 0000 1 0000
M 6 0 00000 07D0 0 0000
A 6 0 00000 0000 0 0008

// File: build.f
+incdir+src
src/pc_bus_pkg.sv
src/bus_decoder.sv
src/main_ram.sv
src/interval_timer.sv
src/int_controller.sv
src/pc_soc_top.sv
testbench/tb_pc_soc.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_pc_soc -o tb_pc_soc
./obj_dir/tb_pc_soc | tee "$LOG"

if grep -q "Finished with errors" "$LOG"; then
  echo "Simulation FAILED, see $LOG"
  exit 1
fi
echo "Simulation passed"
